//--- verilog/csr_pkg.sv
package csr_pkg;

    // ============================================================
    // Widths
    // ============================================================
    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    // ============================================================
    // CSR addresses
    // ============================================================
    // Machine trap setup
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS   = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIE       = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC     = 12'h305;

    // Machine trap handling
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH  = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC      = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE    = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVAL     = 12'h343;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIP       = 12'h344;

    // Machine counters, writable
    localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLE    = 12'hB00;
    localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRET  = 12'hB02;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLEH   = 12'hB80;
    localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRETH = 12'hB82;

    // User mirrors, read only
    localparam logic [CSR_ADDR_W-1:0] CSR_CYCLE     = 12'hC00;
    localparam logic [CSR_ADDR_W-1:0] CSR_INSTRET   = 12'hC02;
    localparam logic [CSR_ADDR_W-1:0] CSR_CYCLEH    = 12'hC80;
    localparam logic [CSR_ADDR_W-1:0] CSR_INSTRETH  = 12'hC82;

    // Custom timer space
    localparam logic [CSR_ADDR_W-1:0] CSR_MTIME     = 12'h7C0;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTIMECMP  = 12'h7C1;

    // ============================================================
    // Trap causes and fixed values
    // ============================================================
    localparam logic [XLEN-1:0] CAUSE_ILLEGAL_INST = 32'h0000_0002;
    localparam logic [XLEN-1:0] CAUSE_BREAKPOINT   = 32'h0000_0003;
    localparam logic [XLEN-1:0] CAUSE_MISALIGNED   = 32'h0000_0004;
    localparam logic [XLEN-1:0] CAUSE_ILLEGAL_CSR  = 32'h0000_000B;
    localparam logic [XLEN-1:0] CAUSE_TIMER_IRQ    = 32'h8000_0007;

    localparam int MSTATUS_MIE_BIT = 3;
    localparam int MIE_MTIE_BIT    = 7;

    // MTIP pending
    localparam logic [XLEN-1:0] MIP_MTIP_VALUE     = 32'h0000_0080;
    // MPIE set, MIE cleared on timer entry
    localparam logic [XLEN-1:0] MSTATUS_TRAP_VALUE = 32'h0000_0080;
    localparam logic [XLEN-1:0] MIE_TRAP_VALUE     = 32'h0000_0808;

    // ============================================================
    // Types
    // ============================================================
    typedef enum logic [1:0] {
        CSR_OP_NONE  = 2'b00,
        CSR_OP_WRITE = 2'b01,
        CSR_OP_SET   = 2'b10,
        CSR_OP_CLEAR = 2'b11
    } csr_op_e;

    typedef struct packed {
        logic                  rd_en;
        csr_op_e               op;
        logic [CSR_ADDR_W-1:0] addr;
        logic                  use_imm;
        logic [XLEN-1:0]       imm;
    } csr_access_t;

    typedef struct packed {
        logic                  en;
        logic [CSR_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } csr_wr_t;

    typedef struct packed {
        logic            illegal_inst;
        logic            misaligned;
        logic            illegal_csr;
        logic            breakpoint;
        logic            timer_taken;
        logic            mret;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] tval;
    } trap_req_t;

    typedef struct packed {
        logic            take;
        logic            timer;
        logic [XLEN-1:0] cause;
        logic [XLEN-1:0] epc;
        logic [XLEN-1:0] tval;
    } trap_update_t;

    typedef struct packed {
        logic            jump_en;
        logic [XLEN-1:0] jump_addr;
        logic            return_en;
        logic [XLEN-1:0] return_addr;
    } pc_update_t;

    typedef struct packed {
        logic [XLEN-1:0] mcycle;
        logic [XLEN-1:0] mcycleh;
        logic [XLEN-1:0] minstret;
        logic [XLEN-1:0] minstreth;
        logic [XLEN-1:0] mtime;
        logic [XLEN-1:0] mtimecmp;
    } counter_vals_t;

    typedef struct packed {
        logic [XLEN-1:0] mstatus;
        logic [XLEN-1:0] mie;
        logic [XLEN-1:0] mip;
        logic [XLEN-1:0] mtvec;
        logic [XLEN-1:0] mscratch;
        logic [XLEN-1:0] mepc;
        logic [XLEN-1:0] mcause;
        logic [XLEN-1:0] mtval;
    } mach_regs_t;

endpackage

//--- verilog/csr_ctrl.sv
`timescale 1ns/1ps

module csr_ctrl
    import csr_pkg::*;
(
    input  csr_access_t     access,
    input  logic [XLEN-1:0] wr_src,
    input  logic [XLEN-1:0] cur_value,
    input  trap_req_t       trap,
    input  logic            timer_pending,
    input  mach_regs_t      regs,
    output logic [XLEN-1:0] rd_data,
    output csr_wr_t         wr,
    output trap_update_t    trap_upd,
    output pc_update_t      pc_update,
    output logic            timer_irq_en
);

    logic [XLEN-1:0] src;
    logic            any_trap;

    // ============================================================
    // Software access
    // ============================================================
    assign rd_data = access.rd_en ? cur_value : '0;
    assign src     = access.use_imm ? access.imm : wr_src;

    always_comb begin
        wr.en   = (access.op != CSR_OP_NONE);
        wr.addr = access.addr;
        case (access.op)
            CSR_OP_WRITE: wr.data = src;
            CSR_OP_SET:   wr.data = cur_value | src;
            CSR_OP_CLEAR: wr.data = cur_value & ~src;
            default:      wr.data = cur_value;
        endcase
    end

    // ============================================================
    // Trap selection, timer wins over all exceptions
    // ============================================================
    assign any_trap = trap.timer_taken | trap.breakpoint | trap.illegal_csr
                    | trap.misaligned | trap.illegal_inst;

    always_comb begin
        trap_upd.take  = any_trap;
        trap_upd.timer = trap.timer_taken;
        trap_upd.epc   = trap.pc;
        trap_upd.tval  = trap.tval;
        if (trap.timer_taken) begin
            trap_upd.cause = CAUSE_TIMER_IRQ;
        end else if (trap.breakpoint) begin
            trap_upd.cause = CAUSE_BREAKPOINT;
        end else if (trap.illegal_csr) begin
            trap_upd.cause = CAUSE_ILLEGAL_CSR;
        end else if (trap.misaligned) begin
            trap_upd.cause = CAUSE_MISALIGNED;
        end else if (trap.illegal_inst) begin
            trap_upd.cause = CAUSE_ILLEGAL_INST;
        end else begin
            trap_upd.cause = '0;
        end
    end

    // Redirects use the registered vector and return address
    always_comb begin
        pc_update.jump_en     = any_trap;
        pc_update.jump_addr   = regs.mtvec;
        pc_update.return_en   = trap.mret;
        pc_update.return_addr = regs.mepc;
    end

    assign timer_irq_en = timer_pending & regs.mstatus[MSTATUS_MIE_BIT]
                        & regs.mie[MIE_MTIE_BIT];

endmodule

//--- verilog/csr_counters.sv
`timescale 1ns/1ps

module csr_counters
    import csr_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  csr_wr_t       wr,
    input  logic          inst_retired,
    output counter_vals_t vals,
    output logic          timer_pending
);

    logic [XLEN-1:0] mcycle_q;
    logic [XLEN-1:0] mcycleh_q;
    logic [XLEN-1:0] minstret_q;
    logic [XLEN-1:0] minstreth_q;
    logic [XLEN-1:0] mtime_q;
    logic [XLEN-1:0] mtimecmp_q;

    logic            cycle_carry;
    logic [XLEN-1:0] mcycle_inc;
    logic            instret_carry;
    logic [XLEN-1:0] minstret_inc;

    // ============================================================
    // Low half increments, carry goes to the high half
    // ============================================================
    always_comb begin
        {cycle_carry, mcycle_inc}     = {1'b0, mcycle_q} + (XLEN+1)'(1);
        {instret_carry, minstret_inc} = {1'b0, minstret_q} + (XLEN+1)'(1);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mcycle_q    <= '0;
            mcycleh_q   <= '0;
            minstret_q  <= '0;
            minstreth_q <= '0;
            mtime_q     <= '0;
            mtimecmp_q  <= '0;
        end else begin
            mcycle_q  <= mcycle_inc;
            mcycleh_q <= mcycleh_q + XLEN'(cycle_carry);
            // Free running, not writable
            mtime_q   <= mtime_q + XLEN'(1);
            if (inst_retired) begin
                minstret_q  <= minstret_inc;
                minstreth_q <= minstreth_q + XLEN'(instret_carry);
            end
            // A written half replaces its increment
            if (wr.en) begin
                case (wr.addr)
                    CSR_MCYCLE:    mcycle_q    <= wr.data;
                    CSR_MCYCLEH:   mcycleh_q   <= wr.data;
                    CSR_MINSTRET:  minstret_q  <= wr.data;
                    CSR_MINSTRETH: minstreth_q <= wr.data;
                    CSR_MTIMECMP:  mtimecmp_q  <= wr.data;
                    default: ;
                endcase
            end
        end
    end

    // Compare of zero means the timer is not armed
    assign timer_pending = (mtime_q >= mtimecmp_q) && (mtime_q != '0)
                        && (mtimecmp_q != '0);

    always_comb begin
        vals.mcycle    = mcycle_q;
        vals.mcycleh   = mcycleh_q;
        vals.minstret  = minstret_q;
        vals.minstreth = minstreth_q;
        vals.mtime     = mtime_q;
        vals.mtimecmp  = mtimecmp_q;
    end

endmodule

//--- verilog/csr_machine_regs.sv
`timescale 1ns/1ps

module csr_machine_regs
    import csr_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  csr_wr_t      wr,
    input  trap_update_t trap_upd,
    input  logic         timer_pending,
    output mach_regs_t   regs
);

    mach_regs_t regs_q;
    mach_regs_t regs_d;

    always_comb begin
        regs_d = regs_q;

        // ============================================================
        // Hardware updates
        // ============================================================
        // Pending timer shows as MTIP
        if (timer_pending) begin
            regs_d.mip = MIP_MTIP_VALUE;
        end

        if (trap_upd.take) begin
            regs_d.mcause = trap_upd.cause;
            regs_d.mepc   = trap_upd.epc;
            if (trap_upd.timer) begin
                // Interrupts off on entry, previous enable kept in MPIE
                regs_d.mstatus = MSTATUS_TRAP_VALUE;
                regs_d.mie     = MIE_TRAP_VALUE;
            end else begin
                // Only exceptions report a trap value
                regs_d.mtval = trap_upd.tval;
            end
        end

        // ============================================================
        // Software writes, last so they win
        // ============================================================
        if (wr.en) begin
            case (wr.addr)
                CSR_MSTATUS: begin
                    regs_d.mstatus = wr.data;
                end
                CSR_MIE: begin
                    regs_d.mie = wr.data;
                end
                CSR_MIP: begin
                    regs_d.mip = wr.data;
                end
                CSR_MTVEC: begin
                    regs_d.mtvec = wr.data;
                end
                CSR_MSCRATCH: begin
                    regs_d.mscratch = wr.data;
                end
                CSR_MEPC: begin
                    regs_d.mepc = wr.data;
                end
                CSR_MCAUSE: begin
                    regs_d.mcause = wr.data;
                end
                CSR_MTVAL: begin
                    regs_d.mtval = wr.data;
                end
                default: ;
            endcase
        end
    end

    // ============================================================
    // State
    // ============================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs_q <= '0;
        end else begin
            regs_q <= regs_d;
        end
    end

    // Registered values only, updates show up a cycle later
    assign regs = regs_q;

endmodule

//--- verilog/csr_read_mux.sv
`timescale 1ns/1ps

module csr_read_mux
    import csr_pkg::*;
(
    input  logic [CSR_ADDR_W-1:0] addr,
    input  counter_vals_t         counters,
    input  mach_regs_t            regs,
    output logic [XLEN-1:0]       cur_value
);

    always_comb begin
        case (addr)
            // ============================================================
            // Machine registers
            // ============================================================
            CSR_MSTATUS:   cur_value = regs.mstatus;
            CSR_MIE:       cur_value = regs.mie;
            CSR_MIP:       cur_value = regs.mip;
            CSR_MTVEC:     cur_value = regs.mtvec;
            CSR_MSCRATCH:  cur_value = regs.mscratch;
            CSR_MEPC:      cur_value = regs.mepc;
            CSR_MCAUSE:    cur_value = regs.mcause;
            CSR_MTVAL:     cur_value = regs.mtval;

            // ============================================================
            // Counters and their user mirrors
            // ============================================================
            CSR_MCYCLE,
            CSR_CYCLE:     cur_value = counters.mcycle;
            CSR_MCYCLEH,
            CSR_CYCLEH:    cur_value = counters.mcycleh;
            CSR_MINSTRET,
            CSR_INSTRET:   cur_value = counters.minstret;
            CSR_MINSTRETH,
            CSR_INSTRETH:  cur_value = counters.minstreth;

            // Timer
            CSR_MTIME:     cur_value = counters.mtime;
            CSR_MTIMECMP:  cur_value = counters.mtimecmp;

            // Anything else reads zero
            default:       cur_value = '0;
        endcase
    end

endmodule

//--- verilog/csr_unit.sv
`timescale 1ns/1ps

module csr_unit
    import csr_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  csr_access_t     access,
    input  logic [XLEN-1:0] wr_src,
    input  trap_req_t       trap,
    input  logic            inst_retired,
    output logic [XLEN-1:0] rd_data,
    output pc_update_t      pc_update,
    output logic            timer_irq_en
);

    // ============================================================
    // Internal wiring
    // ============================================================
    logic [XLEN-1:0] cur_value;
    csr_wr_t         wr;
    trap_update_t    trap_upd;
    counter_vals_t   counter_vals;
    mach_regs_t      mach_regs;
    logic            timer_pending;

    // Decode, write data, trap select and redirect
    csr_ctrl u_ctrl (
        .access        (access),
        .wr_src        (wr_src),
        .cur_value     (cur_value),
        .trap          (trap),
        .timer_pending (timer_pending),
        .regs          (mach_regs),
        .rd_data       (rd_data),
        .wr            (wr),
        .trap_upd      (trap_upd),
        .pc_update     (pc_update),
        .timer_irq_en  (timer_irq_en)
    );

    // Cycle, instret and timer
    csr_counters u_counters (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr            (wr),
        .inst_retired  (inst_retired),
        .vals          (counter_vals),
        .timer_pending (timer_pending)
    );

    // Status and trap registers
    csr_machine_regs u_machine_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr            (wr),
        .trap_upd      (trap_upd),
        .timer_pending (timer_pending),
        .regs          (mach_regs)
    );

    // Old value of the addressed CSR, feeds both read and set/clear
    csr_read_mux u_read_mux (
        .addr      (access.addr),
        .counters  (counter_vals),
        .regs      (mach_regs),
        .cur_value (cur_value)
    );

endmodule

//--- dv/csr_ref_model.svh
`ifndef CSR_REF_MODEL_SVH
`define CSR_REF_MODEL_SVH

// Shadow of the software visible machine state
mach_regs_t      ref_regs;
logic [XLEN-1:0] ref_mtimecmp;

// New CSR value for write, set and clear
function automatic logic [XLEN-1:0] ref_write_value(input csr_op_e op,
        input logic [XLEN-1:0] old, input logic [XLEN-1:0] src);
    case (op)
        CSR_OP_WRITE: return src;
        CSR_OP_SET:   return old | src;
        CSR_OP_CLEAR: return old & ~src;
        default:      return old;
    endcase
endfunction

// Counters are not shadowed and read zero here
function automatic logic [XLEN-1:0] ref_read(input logic [CSR_ADDR_W-1:0] addr);
    case (addr)
        CSR_MSTATUS:  return ref_regs.mstatus;
        CSR_MIE:      return ref_regs.mie;
        CSR_MIP:      return ref_regs.mip;
        CSR_MTVEC:    return ref_regs.mtvec;
        CSR_MSCRATCH: return ref_regs.mscratch;
        CSR_MEPC:     return ref_regs.mepc;
        CSR_MCAUSE:   return ref_regs.mcause;
        CSR_MTVAL:    return ref_regs.mtval;
        CSR_MTIMECMP: return ref_mtimecmp;
        default:      return '0;
    endcase
endfunction

function automatic void ref_apply(input csr_op_e op, input logic [CSR_ADDR_W-1:0] addr,
        input logic [XLEN-1:0] src);
    logic [XLEN-1:0] nv;
    nv = ref_write_value(op, ref_read(addr), src);
    if (op == CSR_OP_NONE) return;
    case (addr)
        CSR_MSTATUS:  ref_regs.mstatus = nv;
        CSR_MIE:      ref_regs.mie = nv;
        CSR_MIP:      ref_regs.mip = nv;
        CSR_MTVEC:    ref_regs.mtvec = nv;
        CSR_MSCRATCH: ref_regs.mscratch = nv;
        CSR_MEPC:     ref_regs.mepc = nv;
        CSR_MCAUSE:   ref_regs.mcause = nv;
        CSR_MTVAL:    ref_regs.mtval = nv;
        CSR_MTIMECMP: ref_mtimecmp = nv;
        default: ;
    endcase
endfunction

// Timer first, then breakpoint, illegal CSR, misaligned, illegal instruction
function automatic void ref_trap(input trap_req_t t);
    logic exc;
    exc = t.breakpoint | t.illegal_csr | t.misaligned | t.illegal_inst;
    if (t.timer_taken) begin
        ref_regs.mcause  = 32'h8000_0007;
        ref_regs.mepc    = t.pc;
        ref_regs.mstatus = 32'h0000_0080;
        ref_regs.mie     = 32'h0000_0808;
    end else if (exc) begin
        ref_regs.mepc   = t.pc;
        ref_regs.mtval  = t.tval;
        ref_regs.mcause = t.breakpoint  ? 32'd3
                        : t.illegal_csr ? 32'd11
                        : t.misaligned  ? 32'd4 : 32'd2;
    end
endfunction

`endif

//--- dv/tb_csr_unit.sv
`timescale 1ns/1ps

module tb_csr_unit
    import csr_pkg::*;
();

    logic            clk = 1'b0;
    logic            rst_n;
    csr_access_t     access;
    logic [XLEN-1:0] wr_src;
    trap_req_t       trap;
    logic            inst_retired;
    logic [XLEN-1:0] rd_data;
    pc_update_t      pc_update;
    logic            timer_irq_en;

    // Expected values armed on the rising edge
    logic            chk_rd;
    logic [XLEN-1:0] exp_rd;
    logic            chk_pc;
    pc_update_t      exp_pc;

    string           test_name;
    int              errors;
    int              mismatches = 0;
    int              err_base;
    int              ok_count;
    int              fail_count;
    int              seed;

    logic [CSR_ADDR_W-1:0] mach_addrs [8] = '{CSR_MSTATUS, CSR_MIE, CSR_MIP, CSR_MTVEC,
                                              CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE, CSR_MTVAL};

`include "csr_ref_model.svh"

    csr_unit u_csr_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .access       (access),
        .wr_src       (wr_src),
        .trap         (trap),
        .inst_retired (inst_retired),
        .rd_data      (rd_data),
        .pc_update    (pc_update),
        .timer_irq_en (timer_irq_en)
    );

    always #4 clk = ~clk;

    // ============================================================
    // Compare on the falling edge
    // ============================================================
    always @(negedge clk) begin
        if (chk_rd) begin
            assert (rd_data === exp_rd) else begin
                $display("MISMATCH %s rd_data expected %h actual %h", test_name, exp_rd, rd_data);
                mismatches++;
            end
        end
        if (chk_pc) begin
            assert (pc_update === exp_pc) else begin
                $display("MISMATCH %s pc_update expected %h actual %h",
                         test_name, exp_pc, pc_update);
                mismatches++;
            end
        end
    end

    // One cycle of stimulus with the redirect expected from the shadow registers
    task automatic drive_cycle(input csr_access_t acc, input logic [XLEN-1:0] src,
            input trap_req_t tr, input logic retire, input logic check,
            input logic [XLEN-1:0] exp_val);
        @(posedge clk);
        access       <= acc;
        wr_src       <= src;
        trap         <= tr;
        inst_retired <= retire;
        chk_rd       <= check;
        exp_rd       <= exp_val;
        chk_pc       <= 1'b1;
        exp_pc       <= '{jump_en: tr.timer_taken | tr.breakpoint | tr.illegal_csr
                                   | tr.misaligned | tr.illegal_inst,
                          jump_addr: ref_regs.mtvec, return_en: tr.mret,
                          return_addr: ref_regs.mepc};
    endtask

    task automatic csr_cmd(input logic rd_en, input csr_op_e op,
            input logic [CSR_ADDR_W-1:0] addr, input logic use_imm,
            input logic [XLEN-1:0] imm, input logic [XLEN-1:0] src);
        csr_access_t acc;
        acc = '{rd_en: rd_en, op: op, addr: addr, use_imm: use_imm, imm: imm};
        drive_cycle(acc, src, '0, 1'b0, 1'b1, rd_en ? ref_read(addr) : '0);
        ref_apply(op, addr, use_imm ? imm : src);
    endtask

    task automatic read_value(input logic [CSR_ADDR_W-1:0] addr, input logic check,
            input logic [XLEN-1:0] exp_val);
        drive_cycle('{rd_en: 1'b1, op: CSR_OP_NONE, addr: addr, use_imm: 1'b0, imm: '0},
                    '0, '0, 1'b0, check, exp_val);
    endtask

    task automatic idle(input logic retire);
        drive_cycle('0, '0, '0, retire, 1'b1, '0);
    endtask

    task automatic trap_pulse(input trap_req_t tr);
        drive_cycle('0, '0, tr, 1'b0, 1'b1, '0);
        ref_trap(tr);
    endtask

    task automatic check_flag(input string what, input logic exp_val, input logic act);
        assert (act === exp_val) else begin
            $display("MISMATCH %s %s expected %0d actual %0d", test_name, what, exp_val, act);
            errors++;
        end
    endtask

    task automatic wait_mip_pending();
        int  n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < 200) begin
            read_value(CSR_MIP, 1'b0, '0);
            @(negedge clk);
            seen = (rd_data === 32'h0000_0080);
            n++;
        end
        if (!seen) begin
            $display("%s: timeout, mip never showed the pending timer", test_name);
            errors++;
        end
    endtask

    task automatic wait_irq_enabled();
        int  n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < 50) begin
            idle(1'b0);
            @(negedge clk);
            seen = timer_irq_en;
            n++;
        end
        if (!seen) begin
            $display("%s: timeout, timer_irq_en never went high", test_name);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_base  = errors + mismatches;
    endtask

    task automatic end_test();
        @(negedge clk);
        #1;
        if (errors + mismatches == err_base) begin
            $display("test %s: ok", test_name);
            ok_count++;
        end else begin
            $display("test %s: FAIL with %0d errors", test_name,
                     errors + mismatches - err_base);
            fail_count++;
        end
    endtask

    // ============================================================
    // Stimulus
    // ============================================================
    initial begin
        logic [XLEN-1:0]       rnd;
        logic [XLEN-1:0]       v;
        logic [XLEN-1:0]       t;
        logic [XLEN-1:0]       h;
        logic [1:0]            sel;
        logic [CSR_ADDR_W-1:0] addr;
        int                    pulses;
        trap_req_t             tr;

        seed         = 44206;
        errors       = 0;
        err_base     = 0;
        ok_count     = 0;
        fail_count   = 0;
        ref_regs     = '0;
        ref_mtimecmp = '0;
        rst_n        <= 1'b0;
        access       <= '0;
        wr_src       <= '0;
        trap         <= '0;
        inst_retired <= 1'b0;
        chk_rd       <= 1'b0;
        exp_rd       <= '0;
        chk_pc       <= 1'b0;
        exp_pc       <= '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        start_test("reset");
        for (int i = 0; i < 8; i++) begin
            csr_cmd(1'b1, CSR_OP_NONE, mach_addrs[i[2:0]], 1'b0, '0, '0);
        end
        csr_cmd(1'b1, CSR_OP_NONE, 12'h123, 1'b0, '0, '0);
        csr_cmd(1'b1, CSR_OP_NONE, 12'hFFF, 1'b0, '0, '0);
        @(negedge clk);
        check_flag("timer_irq_en", 1'b0, timer_irq_en);
        end_test();

        start_test("write_ops");
        for (int i = 0; i < 32; i++) begin
            rnd = $random(seed);
            v   = $random(seed);
            t   = $random(seed);
            sel = (rnd[1:0] == 2'b00) ? 2'b01 : rnd[1:0];
            case (rnd[3:2])
                2'd0:    addr = CSR_MSCRATCH;
                2'd1:    addr = CSR_MTVEC;
                default: addr = CSR_MEPC;
            endcase
            csr_cmd(1'b1, csr_op_e'(sel), addr, rnd[8], {27'b0, v[4:0]}, t);
        end
        csr_cmd(1'b1, CSR_OP_NONE, CSR_MSCRATCH, 1'b0, '0, '0);
        csr_cmd(1'b1, CSR_OP_NONE, CSR_MTVEC, 1'b0, '0, '0);
        csr_cmd(1'b1, CSR_OP_NONE, CSR_MEPC, 1'b0, '0, '0);
        // Gated read of a nonzero register
        csr_cmd(1'b0, CSR_OP_WRITE, CSR_MSCRATCH, 1'b0, '0, 32'hA5A5_5A5A);
        csr_cmd(1'b0, CSR_OP_NONE, CSR_MSCRATCH, 1'b0, '0, '0);
        end_test();

        start_test("mcycle");
        v = $random(seed);
        csr_cmd(1'b0, CSR_OP_WRITE, CSR_MCYCLE, 1'b0, '0, v);
        read_value(CSR_MCYCLE, 1'b1, v);
        repeat (6) idle(1'b0);
        read_value(CSR_MCYCLE, 1'b1, v + 32'd7);
        // Mirror is read only
        read_value(CSR_MCYCLE, 1'b1, v + 32'd8);
        csr_cmd(1'b0, CSR_OP_WRITE, CSR_CYCLE, 1'b0, '0, ~v);
        read_value(CSR_CYCLE, 1'b1, v + 32'd10);
        // Low half wraps into the high half
        h = $random(seed);
        csr_cmd(1'b0, CSR_OP_WRITE, CSR_MCYCLE, 1'b0, '0, '0);
        csr_cmd(1'b0, CSR_OP_WRITE, CSR_MCYCLEH, 1'b0, '0, h);
        csr_cmd(1'b0, CSR_OP_WRITE, CSR_MCYCLE, 1'b0, '0, 32'hFFFF_FFFF);
        read_value(CSR_MCYCLEH, 1'b1, h);
        read_value(CSR_CYCLEH, 1'b1, h + 32'd1);
        end_test();

        start_test("minstret");
        v = $random(seed);
        csr_cmd(1'b0, CSR_OP_WRITE, CSR_MINSTRET, 1'b0, '0, v);
        pulses = 0;
        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            idle(rnd[0]);
            if (rnd[0]) pulses++;
        end
        read_value(CSR_MINSTRET, 1'b1, v + 32'(pulses));
        read_value(CSR_INSTRET, 1'b1, v + 32'(pulses));
        end_test();

        start_test("traps");
        for (int i = 0; i < 12; i++) begin
            rnd = $random(seed);
            tr  = '0;
            if (i < 4) begin
                {tr.illegal_inst, tr.misaligned, tr.illegal_csr, tr.breakpoint} = 4'b0001 << i;
            end else begin
                {tr.illegal_inst, tr.misaligned, tr.illegal_csr, tr.breakpoint} =
                    (rnd[3:0] == 4'd0) ? 4'b0101 : rnd[3:0];
            end
            tr.pc   = $random(seed);
            tr.tval = $random(seed);
            trap_pulse(tr);
            csr_cmd(1'b1, CSR_OP_NONE, CSR_MCAUSE, 1'b0, '0, '0);
            csr_cmd(1'b1, CSR_OP_NONE, CSR_MEPC, 1'b0, '0, '0);
            csr_cmd(1'b1, CSR_OP_NONE, CSR_MTVAL, 1'b0, '0, '0);
        end
        tr      = '0;
        tr.mret = 1'b1;
        trap_pulse(tr);
        end_test();

        start_test("timer");
        read_value(CSR_MTIME, 1'b0, '0);
        @(negedge clk);
        t = rd_data + 32'd40;
        csr_cmd(1'b0, CSR_OP_WRITE, CSR_MTIMECMP, 1'b0, '0, t);
        csr_cmd(1'b1, CSR_OP_NONE, CSR_MTIMECMP, 1'b0, '0, '0);
        csr_cmd(1'b1, CSR_OP_NONE, CSR_MIP, 1'b0, '0, '0);
        @(negedge clk);
        check_flag("timer_irq_en", 1'b0, timer_irq_en);
        wait_mip_pending();
        ref_regs.mip = 32'h0000_0080;
        check_flag("timer_irq_en", 1'b0, timer_irq_en);
        csr_cmd(1'b1, CSR_OP_SET, CSR_MSTATUS, 1'b1, 32'h0000_0008, '0);
        csr_cmd(1'b1, CSR_OP_NONE, CSR_MIP, 1'b0, '0, '0);
        @(negedge clk);
        check_flag("timer_irq_en", 1'b0, timer_irq_en);
        csr_cmd(1'b1, CSR_OP_SET, CSR_MIE, 1'b0, '0, 32'h0000_0080);
        wait_irq_enabled();
        tr             = '0;
        tr.timer_taken = 1'b1;
        tr.pc          = $random(seed);
        trap_pulse(tr);
        csr_cmd(1'b1, CSR_OP_NONE, CSR_MCAUSE, 1'b0, '0, '0);
        csr_cmd(1'b1, CSR_OP_NONE, CSR_MSTATUS, 1'b0, '0, '0);
        csr_cmd(1'b1, CSR_OP_NONE, CSR_MIE, 1'b0, '0, '0);
        csr_cmd(1'b1, CSR_OP_NONE, CSR_MEPC, 1'b0, '0, '0);
        @(negedge clk);
        check_flag("timer_irq_en", 1'b0, timer_irq_en);
        end_test();

        $display("tests: %0d ok, %0d with errors, %0d errors in total",
                 ok_count, fail_count, errors + mismatches);
        if (fail_count == 0 && errors == 0 && mismatches == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- csr_unit.f
+incdir+dv
verilog/csr_pkg.sv
verilog/csr_ctrl.sv
verilog/csr_counters.sv
verilog/csr_machine_regs.sv
verilog/csr_read_mux.sv
verilog/csr_unit.sv
dv/tb_csr_unit.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the csr_unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_csr_unit \
    -f csr_unit.f --Mdir obj_dir -o sim_csr_unit
if [ $? -ne 0 ]; then
    echo "verilator build error"
    exit 1
fi

out=$(./obj_dir/sim_csr_unit)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
